// File: Makefile
# Verilator simulation of rsa_core, all variables may be overridden
VERILATOR ?= verilator
TOP       ?= rsa_core_tb
FILELIST  ?= rsa_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/key_generator.sv
`timescale 1ns/1ps

module key_generator import rsa_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   key_valid,
    output logic                   key_ready,
    input  logic [PRIME_WIDTH-1:0] p,
    input  logic [PRIME_WIDTH-1:0] q,
    output logic                   keygen_busy,
    output logic                   keys_done,
    output logic [WORD_WIDTH-1:0]  modulus,
    output logic [WORD_WIDTH-1:0]  e_found,
    output logic [WORD_WIDTH-1:0]  d_found
);

    logic [1:0]                   state;
    logic [PRIME_WIDTH-1:0]       p_reg, q_reg;  // Primes captured at the request
    logic [WORD_WIDTH-1:0]        totient;
    logic [WORD_WIDTH-1:0]        e_cand;        // Exponent under test
    logic [WORD_WIDTH-1:0]        a_reg, b_reg;  // Euclid pair, gcd ends up in a_reg
    logic signed [COEF_WIDTH-1:0] x_prev;        // Coefficient of a_reg w.r.t. e_cand
    logic signed [COEF_WIDTH-1:0] x_curr;        // Coefficient of b_reg
    logic signed [COEF_WIDTH-1:0] x_next;
    logic signed [COEF_WIDTH-1:0] d_adj;
    logic [WORD_WIDTH-1:0]        euclid_q, euclid_r;

    // n and phi(n) straight from the stored primes
    assign modulus = WORD_WIDTH'(p_reg) * WORD_WIDTH'(q_reg);
    assign totient = WORD_WIDTH'(p_reg - 1'b1) * WORD_WIDTH'(q_reg - 1'b1);

    // a_reg divided by b_reg each Euclid step
    restoring_divider #(
        .dividend_width(WORD_WIDTH),
        .divisor_width (WORD_WIDTH)
    ) euclid_div (
        .dividend (a_reg),
        .divisor  (b_reg),
        .quotient (euclid_q),
        .remainder(euclid_r)
    );

    // Coefficient update, x_prev - q * x_curr
    // Magnitudes stay below the totient so COEF_WIDTH bits hold the exact value
    assign x_next = x_prev - x_curr * $signed({1'b0, euclid_q});

    // Negative coefficient is folded back into 0..totient-1
    assign d_adj   = x_prev + $signed({1'b0, totient});
    assign d_found = x_prev[COEF_WIDTH-1] ? d_adj[WORD_WIDTH-1:0] : x_prev[WORD_WIDTH-1:0];
    assign e_found = e_cand;

    assign key_ready   = (state == KG_IDLE);
    assign keygen_busy = (state != KG_IDLE);
    assign keys_done   = (state == KG_CHECK) && (a_reg == WORD_WIDTH'(1));  // gcd of 1 accepts

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= KG_IDLE;
        end else begin
            case (state)
                KG_IDLE:   if (key_valid) state <= KG_INIT;
                KG_INIT:   state <= KG_EUCLID;
                KG_EUCLID: if (b_reg == '0) state <= KG_CHECK;  // Remainder hit zero
                KG_CHECK:  state <= keys_done ? KG_IDLE : KG_INIT;
                default:   state <= KG_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        case (state)
            KG_IDLE: begin
                if (key_valid) begin
                    p_reg  <= p;
                    q_reg  <= q;
                    e_cand <= FIRST_E;
                end
            end
            KG_INIT: begin
                a_reg  <= totient;  // gcd(totient, e_cand)
                b_reg  <= e_cand;
                x_prev <= '0;
                x_curr <= COEF_WIDTH'(1);
            end
            KG_EUCLID: begin
                if (b_reg != '0) begin
                    a_reg  <= b_reg;
                    b_reg  <= euclid_r;
                    x_prev <= x_curr;
                    x_curr <= x_next;
                end
            end
            KG_CHECK: if (!keys_done) e_cand <= e_cand + E_STEP;  // Next odd candidate
            default: ;
        endcase
    end

endmodule

// File: hdl/key_store.sv
`timescale 1ns/1ps

module key_store import rsa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  keygen_busy,
    input  logic                  keys_done,
    input  logic [WORD_WIDTH-1:0] modulus,
    input  logic [WORD_WIDTH-1:0] e_found,
    input  logic [WORD_WIDTH-1:0] d_found,
    input  logic                  encrypt,
    output logic                  keys_ready,
    output logic [WORD_WIDTH-1:0] modulus_out,
    output logic [WORD_WIDTH-1:0] public_e,
    output logic [WORD_WIDTH-1:0] exponent_sel
);

    logic [WORD_WIDTH-1:0] n_reg;
    logic [WORD_WIDTH-1:0] e_reg;
    logic [WORD_WIDTH-1:0] d_reg;   // Private, only reaches the engine
    logic                  loaded;  // A key set has been stored at least once

    // ====================
    // Key registers
    // ====================
    always_ff @(posedge clk) begin
        if (keys_done) begin
            n_reg <= modulus;
            e_reg <= e_found;
            d_reg <= d_found;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loaded <= 1'b0;
        end else if (keys_done) begin
            loaded <= 1'b1;
        end
    end

    // Stored keys count as stale while a new set is being generated
    assign keys_ready = loaded && !keygen_busy;

    // Public half goes out, exponent for the engine picked per message
    assign modulus_out  = n_reg;
    assign public_e     = e_reg;
    assign exponent_sel = encrypt ? e_reg : d_reg;

endmodule

// File: hdl/mod_exp_engine.sv
`timescale 1ns/1ps

module mod_exp_engine import rsa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  keys_ready,
    input  logic                  msg_valid,
    output logic                  msg_ready,
    input  logic [WORD_WIDTH-1:0] msg,
    input  logic [WORD_WIDTH-1:0] modulus_in,
    input  logic [WORD_WIDTH-1:0] exponent_in,
    output logic                  result_valid,
    input  logic                  result_ready,
    output logic [WORD_WIDTH-1:0] result
);

    logic [1:0]            state;
    logic [WORD_WIDTH-1:0] base_reg;    // msg^(2^k) mod n
    logic [WORD_WIDTH-1:0] mod_reg;     // n latched per message
    logic [WORD_WIDTH-1:0] exp_reg;     // Remaining exponent bits
    logic [WORD_WIDTH-1:0] result_reg;  // Running product
    logic [PROD_WIDTH-1:0] square_full;
    logic [PROD_WIDTH-1:0] multiply_full;
    logic [WORD_WIDTH-1:0] square_mod;
    logic [WORD_WIDTH-1:0] multiply_mod;
    logic                  msg_fire;

    assign msg_ready    = (state == EX_IDLE) && keys_ready;
    assign msg_fire     = msg_valid && msg_ready;
    assign result_valid = (state == EX_DONE);
    assign result       = result_reg;

    // Full 32 bit products, reduced without truncation
    assign square_full   = PROD_WIDTH'(base_reg) * PROD_WIDTH'(base_reg);
    assign multiply_full = PROD_WIDTH'(result_reg) * PROD_WIDTH'(base_reg);

    restoring_divider #(
        .dividend_width(PROD_WIDTH),
        .divisor_width (WORD_WIDTH)
    ) square_div (
        .dividend (square_full),
        .divisor  (mod_reg),
        .quotient (),
        .remainder(square_mod)
    );

    restoring_divider #(
        .dividend_width(PROD_WIDTH),
        .divisor_width (WORD_WIDTH)
    ) multiply_div (
        .dividend (multiply_full),
        .divisor  (mod_reg),
        .quotient (),
        .remainder(multiply_mod)
    );

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= EX_IDLE;
        end else begin
            case (state)
                EX_IDLE: if (msg_fire) state <= EX_RUN;
                EX_RUN:  if (exp_reg == '0) state <= EX_DONE;  // All bits consumed
                EX_DONE: if (result_ready) state <= EX_IDLE;   // Held under back-pressure
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Right to left square and multiply, one exponent bit per cycle
    always_ff @(posedge clk) begin
        if (state == EX_IDLE && msg_fire) begin
            base_reg   <= msg;  // Assumed below n
            mod_reg    <= modulus_in;
            exp_reg    <= exponent_in;
            result_reg <= WORD_WIDTH'(1);
        end else if (state == EX_RUN && exp_reg != '0) begin
            if (exp_reg[0]) result_reg <= multiply_mod;  // Bit set, fold base in
            base_reg <= square_mod;
            exp_reg  <= exp_reg >> 1;
        end
    end

endmodule

// File: hdl/restoring_divider.sv
`timescale 1ns/1ps

module restoring_divider #(
    parameter int dividend_width = 16,
    parameter int divisor_width  = 16
) (
    input  logic [dividend_width-1:0] dividend,
    input  logic [divisor_width-1:0]  divisor,
    output logic [dividend_width-1:0] quotient,
    output logic [divisor_width-1:0]  remainder
);

    // Partial remainder carries one extra bit for the sign of the trial subtraction
    logic [divisor_width:0] partial;
    logic [divisor_width:0] trial;

    // ====================
    // Bit serial division, unrolled
    // ====================
    always_comb begin
        partial  = '0;
        trial    = '0;
        quotient = '0;
        for (int i = dividend_width - 1; i >= 0; i--) begin
            // Bring down the next dividend bit
            partial = {partial[divisor_width-1:0], dividend[i]};
            trial   = partial - {1'b0, divisor};  // Try to take the divisor out
            if (trial[divisor_width]) begin
                quotient[i] = 1'b0;  // Went negative, keep old partial
            end else begin
                partial     = trial;  // Subtraction fits
                quotient[i] = 1'b1;
            end
        end
        // Partial stays below the divisor, so the top bit is always clear here
        remainder = partial[divisor_width-1:0];
    end

endmodule

// File: hdl/rsa_core.sv
`timescale 1ns/1ps

module rsa_core import rsa_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   key_valid,
    output logic                   key_ready,
    input  logic [PRIME_WIDTH-1:0] p,
    input  logic [PRIME_WIDTH-1:0] q,
    output logic                   keys_ready,
    output logic [WORD_WIDTH-1:0]  modulus_out,
    output logic [WORD_WIDTH-1:0]  public_e,
    input  logic                   msg_valid,
    output logic                   msg_ready,
    input  logic [WORD_WIDTH-1:0]  msg,
    input  logic                   encrypt,
    output logic                   result_valid,
    input  logic                   result_ready,
    output logic [WORD_WIDTH-1:0]  result
);

    // Generator to store
    logic                  keygen_busy;
    logic                  keys_done;
    logic [WORD_WIDTH-1:0] modulus;
    logic [WORD_WIDTH-1:0] e_found;
    logic [WORD_WIDTH-1:0] d_found;
    logic [WORD_WIDTH-1:0] exponent_sel;  // Store to engine, e or d

    key_generator key_generator_inst (
        .clk        (clk),
        .reset      (reset),
        .key_valid  (key_valid),
        .key_ready  (key_ready),
        .p          (p),
        .q          (q),
        .keygen_busy(keygen_busy),
        .keys_done  (keys_done),
        .modulus    (modulus),
        .e_found    (e_found),
        .d_found    (d_found)
    );

    key_store key_store_inst (
        .clk         (clk),
        .reset       (reset),
        .keygen_busy (keygen_busy),
        .keys_done   (keys_done),
        .modulus     (modulus),
        .e_found     (e_found),
        .d_found     (d_found),
        .encrypt     (encrypt),
        .keys_ready  (keys_ready),
        .modulus_out (modulus_out),
        .public_e    (public_e),
        .exponent_sel(exponent_sel)
    );

    // Engine latches n and exponent at the message transfer
    mod_exp_engine mod_exp_engine_inst (
        .clk         (clk),
        .reset       (reset),
        .keys_ready  (keys_ready),
        .msg_valid   (msg_valid),
        .msg_ready   (msg_ready),
        .msg         (msg),
        .modulus_in  (modulus_out),
        .exponent_in (exponent_sel),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result      (result)
    );

endmodule

// File: hdl/rsa_pkg.sv
package rsa_pkg;

    // ====================
    // Datapath widths
    // ====================
    localparam int PRIME_WIDTH = 8;                // p and q
    localparam int WORD_WIDTH  = 16;               // n, totient, e, d, message, result
    localparam int PROD_WIDTH  = 2 * WORD_WIDTH;   // Full product of two words
    localparam int COEF_WIDTH  = WORD_WIDTH + 1;   // Bezout coefficient plus sign bit

    // Public exponent search
    // Smallest usable odd exponent
    localparam logic [WORD_WIDTH-1:0] FIRST_E = WORD_WIDTH'(3);
    localparam logic [WORD_WIDTH-1:0] E_STEP  = WORD_WIDTH'(2);  // Stay on odd values

    // ====================
    // Key generator FSM
    // ====================
    localparam logic [1:0] KG_IDLE   = 2'd0;  // Waiting for key request
    localparam logic [1:0] KG_INIT   = 2'd1;  // Load Euclid registers for a candidate
    localparam logic [1:0] KG_EUCLID = 2'd2;  // One division step per cycle
    localparam logic [1:0] KG_CHECK  = 2'd3;  // gcd test, accept or try next candidate

    // ====================
    // Exponentiation FSM
    // ====================
    localparam logic [1:0] EX_IDLE = 2'd0;  // Ready for a message
    localparam logic [1:0] EX_RUN  = 2'd1;  // Square and multiply
    localparam logic [1:0] EX_DONE = 2'd2;  // Result held until accepted

endpackage

// File: rsa_core.f
hdl/rsa_pkg.sv
hdl/restoring_divider.sv
hdl/key_generator.sv
hdl/key_store.sv
hdl/mod_exp_engine.sv
hdl/rsa_core.sv
verification/rsa_core_tb.sv

// File: verification/rsa_core_tb.sv
`timescale 1ns/1ps

module rsa_core_tb import rsa_pkg::*; ();

    localparam int NUM_ROWS        = 8;
    localparam int NUM_PAIRS       = 5;
    localparam int RANDOM_PER_PAIR = 3;
    localparam int KEY_TIMEOUT     = 2000;  // Cycles for several candidates plus Euclid steps
    localparam int MSG_TIMEOUT     = 200;   // About one cycle per exponent bit plus margin

    logic                   clk, reset;
    logic                   key_valid, key_ready;
    logic [PRIME_WIDTH-1:0] p, q;
    logic                   keys_ready;
    logic [WORD_WIDTH-1:0]  modulus_out, public_e;
    logic                   msg_valid, msg_ready;
    logic [WORD_WIDTH-1:0]  msg;
    logic                   encrypt;
    logic                   result_valid, result_ready;
    logic [WORD_WIDTH-1:0]  result;

    // ====================
    // Stimulus table
    // ====================
    int unsigned row_p     [NUM_ROWS] = '{11, 11, 61, 61, 17, 251, 251, 3};
    int unsigned row_q     [NUM_ROWS] = '{13, 13, 53, 53, 23, 241, 241, 5};
    int unsigned row_msg   [NUM_ROWS] = '{42, 100, 1234, 3000, 77, 60000, 12345, 7};
    bit          row_enc   [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    int          row_stall [NUM_ROWS] = '{0, 3, 2, 0, 5, 1, 4, 2};  // result_ready held low
    // Key pairs for the random message pass
    int unsigned pair_p [NUM_PAIRS] = '{11, 61, 17, 251, 3};
    int unsigned pair_q [NUM_PAIRS] = '{13, 53, 23, 241, 5};

    int unsigned cur_p, cur_q, cur_n, cur_tot, cur_e, cur_d;  // Model of the stored keys
    int          error_count, check_count;
    bit          aborted;  // Set by a timeout so the rest of the run is skipped
    int          seed;

    rsa_core rsa_core_inst (
        .clk(clk), .reset(reset),
        .key_valid(key_valid), .key_ready(key_ready), .p(p), .q(q),
        .keys_ready(keys_ready), .modulus_out(modulus_out), .public_e(public_e),
        .msg_valid(msg_valid), .msg_ready(msg_ready), .msg(msg), .encrypt(encrypt),
        .result_valid(result_valid), .result_ready(result_ready), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // ====================
    // Reference model
    // ====================
    function automatic int unsigned gcd_of(input int unsigned a, input int unsigned b);
        int unsigned x, y, t;
        x = a;
        y = b;
        while (y != 0) begin
            t = x % y;
            x = y;
            y = t;
        end
        return x;
    endfunction

    // Smallest odd exponent from 3 up that is coprime to the totient
    function automatic int unsigned smallest_e(input int unsigned tot);
        int unsigned cand;
        cand = 3;
        while (gcd_of(tot, cand) != 1) cand += 2;
        return cand;
    endfunction

    // Extended Euclid tracking only the coefficient of e
    function automatic int unsigned inverse_mod(input int unsigned e, input int unsigned tot);
        longint old_r, r, old_t, t, quo, tmp;
        old_r = longint'(tot);
        r     = longint'(e);
        old_t = 0;
        t     = 1;
        while (r != 0) begin
            quo   = old_r / r;
            tmp   = old_r - quo * r;
            old_r = r;
            r     = tmp;
            tmp   = old_t - quo * t;
            old_t = t;
            t     = tmp;
        end
        if (old_t < 0) old_t = old_t + longint'(tot);  // Fold into 0..tot-1
        return 32'(old_t);
    endfunction

    // Modular power by plain repeated multiplication
    function automatic int unsigned power_mod(input int unsigned base,
                                              input int unsigned exponent,
                                              input int unsigned n);
        longint unsigned acc;
        acc = 1;
        for (int unsigned i = 0; i < exponent; i++) begin
            acc = (acc * 64'(base)) % 64'(n);
        end
        return 32'(acc);
    endfunction

    // ====================
    // Checks and handshakes
    // ====================
    task automatic check_value(input string name, input int unsigned got,
                               input int unsigned expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %0d got %0d", $time, name, expected, got);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        aborted = 1'b1;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    task automatic request_keys(input int unsigned new_p, input int unsigned new_q);
        int cycles;
        if (!aborted) begin
            @(posedge clk);
            key_valid <= 1'b1;
            p         <= PRIME_WIDTH'(new_p);
            q         <= PRIME_WIDTH'(new_q);
            @(negedge clk);
            cycles = 0;
            while (!key_ready && cycles < KEY_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!key_ready) begin
                report_timeout("key_ready stayed low, key request not accepted");
            end else begin
                @(posedge clk);  // Transfer edge
                key_valid <= 1'b0;
                @(negedge clk);
                check_value("keys_ready", 32'(keys_ready), 0);  // Old keys now stale
                cycles = 0;
                while (!keys_ready && cycles < KEY_TIMEOUT) begin
                    check_value("msg_ready", 32'(msg_ready), 0);  // No message while keys build
                    @(negedge clk);
                    cycles++;
                end
                if (!keys_ready) begin
                    report_timeout("keys_ready did not return after a key request");
                end else begin
                    cur_p   = new_p;
                    cur_q   = new_q;
                    cur_n   = new_p * new_q;
                    cur_tot = (new_p - 1) * (new_q - 1);
                    cur_e   = smallest_e(cur_tot);
                    cur_d   = inverse_mod(cur_e, cur_tot);
                    check_value("modulus_out", 32'(modulus_out), cur_n);
                    check_value("public_e", 32'(public_e), cur_e);
                end
            end
        end
    endtask

    // One message in and one result out with result_ready held low for stall cycles
    task automatic exchange_message(input int unsigned m, input bit enc, input int stall,
                                    output int unsigned got);
        int cycles;
        got = 0;
        if (!aborted) begin
            @(posedge clk);
            msg_valid <= 1'b1;
            msg       <= WORD_WIDTH'(m);
            encrypt   <= enc;
            @(negedge clk);
            cycles = 0;
            while (!msg_ready && cycles < MSG_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!msg_ready) begin
                report_timeout("msg_ready stayed low with keys loaded");
            end else begin
                @(posedge clk);  // Message transfer
                msg_valid <= 1'b0;
                @(negedge clk);
                cycles = 0;
                while (!result_valid && cycles < MSG_TIMEOUT) begin
                    @(negedge clk);
                    cycles++;
                end
                if (!result_valid) begin
                    report_timeout("result_valid did not rise after a message");
                end else begin
                    got = 32'(result);
                    for (int i = 0; i < stall; i++) begin
                        @(negedge clk);
                        check_value("result_valid", 32'(result_valid), 1);
                        check_value("result", 32'(result), got);  // Held under stall
                        check_value("msg_ready", 32'(msg_ready), 0);
                    end
                    @(posedge clk);
                    result_ready <= 1'b1;
                    @(posedge clk);  // Result transfer
                    result_ready <= 1'b0;
                end
            end
        end
    endtask

    // First pass in the given direction and then back with the other exponent
    task automatic round_trip(input int unsigned m, input bit enc, input int stall);
        int unsigned expected, got_first, got_back;
        expected = enc ? power_mod(m, cur_e, cur_n) : power_mod(m, cur_d, cur_n);
        exchange_message(m, enc, stall, got_first);
        if (!aborted) check_value("result", got_first, expected);
        exchange_message(expected, !enc, 0, got_back);
        if (!aborted) check_value("result", got_back, m);  // Must recover the message
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int rnd;
        reset        = 1'b1;
        key_valid    = 1'b0;
        p            = '0;
        q            = '0;
        msg_valid    = 1'b0;
        msg          = '0;
        encrypt      = 1'b0;
        result_ready = 1'b0;
        error_count  = 0;
        check_count  = 0;
        aborted      = 1'b0;
        seed         = 32'hed22;
        cur_p        = 0;
        cur_q        = 0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("key_ready", 32'(key_ready), 1);     // Idle after reset
        check_value("keys_ready", 32'(keys_ready), 0);
        check_value("msg_ready", 32'(msg_ready), 0);
        check_value("result_valid", 32'(result_valid), 0);

        // Table rows request new keys only when the pair changes
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_p[r] != cur_p || row_q[r] != cur_q) request_keys(row_p[r], row_q[r]);
            round_trip(row_msg[r], row_enc[r], row_stall[r]);
        end

        // Random messages below n under fresh keys
        for (int k = 0; k < NUM_PAIRS; k++) begin
            request_keys(pair_p[k], pair_q[k]);
            for (int j = 0; j < RANDOM_PER_PAIR; j++) begin
                rnd = $random(seed);
                round_trip($unsigned(rnd) % cur_n, 1'b1, j);
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
